//--- hart_ctrl.f
src/hart_csr_pkg.sv
src/hart_ctrl_pkg.sv
src/hart_int_controller.sv
src/hart_cs_registers.sv
src/hart_cycle_counter.sv
src/hart_controller_fsm.sv
src/hart_ctrl_top.sv
+incdir+test
test/tb_hart_ctrl.sv

//--- Makefile
SIM := obj_dir/Vtb_hart_ctrl
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(SIM): hart_ctrl.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hart_ctrl -f hart_ctrl.f

sim.log: $(SIM)
	./$(SIM) > sim.log 2>&1 || true

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^Testbench passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_hart_ctrl_model.svh
`ifndef TB_HART_CTRL_MODEL_SVH
`define TB_HART_CTRL_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model state, advanced once per rising edge
////////////////////////////////////////////////////////////////////////////

hart_csr_pkg::csr_data_t    m_mip;
hart_csr_pkg::csr_data_t    m_mie;
logic                       m_mstatus_mie;
logic                       m_mstatus_mpie;
hart_ctrl_pkg::ctrl_state_e m_state;
logic                       m_take;
hart_ctrl_pkg::irq_id_t     m_id;
hart_csr_pkg::csr_data_t    m_mcycle;
int                         err_cnt;

// Fast lines 31 down to 16, then external, software, timer
function automatic hart_ctrl_pkg::irq_id_t prio_pick(hart_csr_pkg::csr_data_t pend);
  hart_ctrl_pkg::irq_id_t id;
  logic found;
  id = '0;
  found = 1'b0;
  for (int b = 31; b >= 16; b--) begin
    if (!found && pend[b]) begin
      id = hart_ctrl_pkg::irq_id_t'(b);
      found = 1'b1;
    end
  end
  if (!found && pend[11]) begin
    id = 5'd11;
    found = 1'b1;
  end
  if (!found && pend[3]) begin
    id = 5'd3;
    found = 1'b1;
  end
  if (!found && pend[7]) begin
    id = 5'd7;
  end
  return id;
endfunction

// MIE as software sees it, already clear in the ack cycle
function automatic logic vis_mie();
  return m_take ? 1'b0 : m_mstatus_mie;
endfunction

function automatic hart_csr_pkg::csr_data_t model_read(hart_csr_pkg::csr_addr_t addr);
  hart_csr_pkg::csr_data_t d;
  d = '0;
  case (addr)
    hart_csr_pkg::CSR_MSTATUS: begin
      d[3] = vis_mie();
      d[7] = m_take ? m_mstatus_mie : m_mstatus_mpie;
    end
    hart_csr_pkg::CSR_MIE:    d = m_mie;
    hart_csr_pkg::CSR_MIP:    d = m_mip;
    hart_csr_pkg::CSR_MCYCLE: d = m_mcycle;
    default:                  d = '0;
  endcase
  return d;
endfunction

task automatic model_reset();
  m_mip = '0;
  m_mie = '0;
  m_mstatus_mie = 1'b0;
  m_mstatus_mpie = 1'b0;
  m_state = hart_ctrl_pkg::RESET;
  m_take = 1'b0;
  m_mcycle = '0;
endtask

// Everything computed from the values before the edge
task automatic model_clock();
  hart_csr_pkg::csr_data_t pend;
  logic req;
  logic take_next;
  if (rst) begin
    model_reset();
  end else begin
    pend = m_mip & m_mie;
    req = (pend != '0) && vis_mie();
    take_next = (m_state == hart_ctrl_pkg::ACTIVE) && req;
    // Take first, then mret, then software
    if (m_take) begin
      m_mstatus_mpie = m_mstatus_mie;
      m_mstatus_mie = 1'b0;
    end else if (mret) begin
      m_mstatus_mie = m_mstatus_mpie;
      m_mstatus_mpie = 1'b1;
    end else if (csr_we && csr_addr == hart_csr_pkg::CSR_MSTATUS) begin
      m_mstatus_mie = csr_wdata[3];
      m_mstatus_mpie = csr_wdata[7];
    end
    if (csr_we && csr_addr == hart_csr_pkg::CSR_MIE) begin
      m_mie = csr_wdata & hart_csr_pkg::IRQ_MASK;
    end
    if (csr_we && csr_addr == hart_csr_pkg::CSR_MCYCLE) begin
      m_mcycle = csr_wdata;
    end else if (m_state == hart_ctrl_pkg::ACTIVE) begin
      m_mcycle = m_mcycle + 32'd1;
    end
    if (take_next) begin
      m_id = prio_pick(pend);
    end
    m_take = take_next;
    case (m_state)
      hart_ctrl_pkg::RESET: m_state = hart_ctrl_pkg::BOOT_WAIT;
      hart_ctrl_pkg::BOOT_WAIT: begin
        if (fetch_enable) m_state = hart_ctrl_pkg::ACTIVE;
      end
      hart_ctrl_pkg::ACTIVE: begin
        if (!req && wfi) m_state = hart_ctrl_pkg::SLEEP;
      end
      default: begin
        // Wakeup does not need MIE
        if (pend != '0) m_state = hart_ctrl_pkg::ACTIVE;
      end
    endcase
    m_mip = irq & hart_csr_pkg::IRQ_MASK;
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_data(string name, hart_csr_pkg::csr_data_t got,
                          hart_csr_pkg::csr_data_t exp);
  if (got !== exp) begin
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_id(string name, hart_ctrl_pkg::irq_id_t got,
                        hart_ctrl_pkg::irq_id_t exp);
  if (got !== exp) begin
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  end
endtask

`endif

//--- test/tb_hart_ctrl.sv
`timescale 1ns/1ps

module tb_hart_ctrl;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_CSR        = 200;
  localparam int N_IRQ        = 40;
  localparam int N_MRET       = 20;
  localparam int N_MCYCLE     = 300;
  localparam int WAIT_MAX     = 8;
  // Worst case per test, every wait counted at its limit
  localparam int TOTAL_CYCLES = RESET_CYCLES + 5 + 2 * N_CSR + N_IRQ * (3 + WAIT_MAX)
                              + N_MRET * (2 + WAIT_MAX) + 16 + WAIT_MAX + N_MCYCLE + 4;

  logic                     clk;
  logic                     rst;
  logic                     csr_we;
  hart_csr_pkg::csr_addr_t  csr_addr;
  hart_csr_pkg::csr_data_t  csr_wdata;
  hart_csr_pkg::csr_data_t  csr_rdata;
  logic [31:0]              irq;
  logic                     fetch_enable;
  logic                     wfi;
  logic                     mret;
  logic                     irq_ack;
  hart_ctrl_pkg::irq_id_t   irq_id;
  logic                     core_sleep;
  logic                     active;
  int                       test_err_base;
  int                       tests_run;

  `include "tb_hart_ctrl_model.svh"

  hart_ctrl_top i_dut (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .csr_we_i       ( csr_we       ),
    .csr_addr_i     ( csr_addr     ),
    .csr_wdata_i    ( csr_wdata    ),
    .csr_rdata_o    ( csr_rdata    ),
    .irq_i          ( irq          ),
    .fetch_enable_i ( fetch_enable ),
    .wfi_i          ( wfi          ),
    .mret_i         ( mret         ),
    .irq_ack_o      ( irq_ack      ),
    .irq_id_o       ( irq_id       ),
    .core_sleep_o   ( core_sleep   ),
    .active_o       ( active       )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cycle helpers
  ////////////////////////////////////////////////////////////////////////////

  // One edge for DUT and model, status checked at the falling edge
  task automatic step();
    @(posedge clk);
    model_clock();
    @(negedge clk);
    check_bit("irq_ack_o", irq_ack, m_take);
    if (m_take) begin
      check_id("irq_id_o", irq_id, m_id);
    end
    check_bit("core_sleep_o", core_sleep, m_state == hart_ctrl_pkg::SLEEP);
    check_bit("active_o", active, m_state == hart_ctrl_pkg::ACTIVE);
  endtask

  // Read data is combinational, let the new address settle
  task automatic check_read();
    #1;
    check_data("csr_rdata_o", csr_rdata, model_read(csr_addr));
  endtask

  task automatic csr_write(hart_csr_pkg::csr_addr_t addr, hart_csr_pkg::csr_data_t data);
    csr_we = 1'b1;
    csr_addr = addr;
    csr_wdata = data;
    check_read();
    step();
    csr_we = 1'b0;
  endtask

  task automatic wait_ack(output int n);
    n = 0;
    do begin
      check_read();
      step();
      n++;
    end while (!irq_ack && n < WAIT_MAX);
    if (!irq_ack) begin
      $display("Interrupt acknowledge did not arrive within %0d cycles", WAIT_MAX);
      err_cnt++;
    end
  endtask

  function automatic hart_csr_pkg::csr_addr_t rand_addr();
    case ($urandom_range(0, 4))
      0: return hart_csr_pkg::CSR_MSTATUS;
      1: return hart_csr_pkg::CSR_MIE;
      2: return hart_csr_pkg::CSR_MIP;
      3: return hart_csr_pkg::CSR_MCYCLE;
      default: return hart_csr_pkg::csr_addr_t'($urandom());
    endcase
  endfunction

  task automatic end_test(string name);
    $display("test %0d %s: %0d errors", tests_run + 1, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
    tests_run++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    hart_csr_pkg::csr_data_t en;
    hart_csr_pkg::csr_data_t lines;
    int n;
    int r;
    logic saw_ack;
    void'($urandom(32'h1ffa));
    rst = 1'b1;
    csr_we = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    irq = '0;
    fetch_enable = 1'b0;
    wfi = 1'b0;
    mret = 1'b0;
    err_cnt = 0;
    test_err_base = 0;
    tests_run = 0;
    model_reset();
    repeat (RESET_CYCLES) step();
    rst = 1'b0;

    // Boot waits for fetch enable
    repeat (3) step();
    fetch_enable = 1'b1;
    step();
    check_bit("active_o", active, 1'b1);
    end_test("boot");

    // Write then read back the same address
    for (int i = 0; i < N_CSR; i++) begin
      csr_addr = rand_addr();
      csr_wdata = $urandom();
      csr_we = 1'b1;
      irq = $urandom();
      check_read();
      step();
      csr_we = 1'b0;
      check_read();
      step();
    end
    end_test("csr_access");

    // Sparse enables and lines, at least one pending bit
    for (int i = 0; i < N_IRQ; i++) begin
      irq = '0;
      en = $urandom() & $urandom() & hart_csr_pkg::IRQ_MASK;
      if (en == '0) en = 32'h0000_0080;
      lines = $urandom() & $urandom();
      if ((lines & en) == '0) lines = lines | en;
      csr_write(hart_csr_pkg::CSR_MIE, en);
      csr_write(hart_csr_pkg::CSR_MSTATUS, 32'h0000_0008);
      csr_addr = hart_csr_pkg::CSR_MSTATUS;
      irq = lines;
      wait_ack(n);
      if (n != 2) begin
        $display("Acknowledge came %0d cycles after the interrupt instead of 2", n);
        err_cnt++;
      end
      #1;
      check_data("mstatus", csr_rdata, 32'h0000_0080);
      step();
    end
    end_test("irq_take");

    // Line from the last take still held and enabled
    for (int i = 0; i < N_MRET; i++) begin
      irq = irq | ($urandom() & $urandom());
      mret = 1'b1;
      check_read();
      step();
      mret = 1'b0;
      wait_ack(n);
      step();
    end
    end_test("mret");

    // Sleep with nothing pending, wake with MIE clear
    irq = '0;
    step();
    step();
    csr_write(hart_csr_pkg::CSR_MSTATUS, 32'h0);
    csr_write(hart_csr_pkg::CSR_MIE, ($urandom() & hart_csr_pkg::IRQ_MASK) | 32'h800);
    wfi = 1'b1;
    step();
    wfi = 1'b0;
    check_bit("core_sleep_o", core_sleep, 1'b1);
    csr_addr = hart_csr_pkg::CSR_MCYCLE;
    repeat (5) begin
      check_read();
      step();
    end
    irq = 32'h0000_0800;
    n = 0;
    saw_ack = 1'b0;
    while (!active && n < WAIT_MAX) begin
      check_read();
      step();
      saw_ack = saw_ack | irq_ack;
      n++;
    end
    if (!active) begin
      $display("Hart did not wake within %0d cycles", WAIT_MAX);
      err_cnt++;
    end
    if (saw_ack) begin
      $display("Interrupt was acknowledged although MIE was clear");
      err_cnt++;
    end
    end_test("sleep");

    // Random loads, sleeps and wakeups around mcycle
    irq = '0;
    csr_write(hart_csr_pkg::CSR_MIE, 32'h0001_0000);
    csr_addr = hart_csr_pkg::CSR_MCYCLE;
    for (int i = 0; i < N_MCYCLE; i++) begin
      r = $urandom_range(0, 15);
      csr_we = (r == 0);
      csr_wdata = $urandom();
      wfi = (r == 1);
      irq = ($urandom_range(0, 9) == 0) ? 32'h0001_0000 : 32'h0;
      check_read();
      step();
    end
    csr_we = 1'b0;
    wfi = 1'b0;
    end_test("mcycle");

    $display("%0d tests run, %0d errors", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- src/hart_ctrl_top.sv
`timescale 1ns/1ps

module hart_ctrl_top (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // CSR access
  input  logic                       csr_we_i,
  input  hart_csr_pkg::csr_addr_t    csr_addr_i,
  input  hart_csr_pkg::csr_data_t    csr_wdata_i,
  output hart_csr_pkg::csr_data_t    csr_rdata_o,

  // Interrupt levels
  input  logic [31:0]                irq_i,

  // Core control and retired instructions
  input  logic                       fetch_enable_i,
  input  logic                       wfi_i,
  input  logic                       mret_i,

  // Status
  output logic                       irq_ack_o,
  output hart_ctrl_pkg::irq_id_t     irq_id_o,
  output logic                       core_sleep_o,
  output logic                       active_o
);

  hart_csr_pkg::csr_data_t  mip;
  hart_csr_pkg::csr_data_t  mie;
  logic                     mstatus_mie;
  hart_csr_pkg::csr_data_t  mcycle;
  logic                     mcycle_we;
  hart_csr_pkg::csr_data_t  mcycle_wdata;
  hart_ctrl_pkg::irq_ctrl_t irq_ctrl;
  hart_ctrl_pkg::ctrl_fsm_t ctrl_fsm;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt controller
  ////////////////////////////////////////////////////////////////////////////

  hart_int_controller int_controller_i (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .irq_i         ( irq_i       ),
    .mie_i         ( mie         ),
    .mstatus_mie_i ( mstatus_mie ),
    .mip_o         ( mip         ),
    .irq_ctrl_o    ( irq_ctrl    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // CSRs and mcycle
  ////////////////////////////////////////////////////////////////////////////

  hart_cs_registers cs_registers_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .csr_we_i       ( csr_we_i     ),
    .csr_addr_i     ( csr_addr_i   ),
    .csr_wdata_i    ( csr_wdata_i  ),
    .csr_rdata_o    ( csr_rdata_o  ),
    .mret_i         ( mret_i       ),
    .ctrl_fsm_i     ( ctrl_fsm     ),
    .mip_i          ( mip          ),
    .mcycle_i       ( mcycle       ),
    .mie_o          ( mie          ),
    .mstatus_mie_o  ( mstatus_mie  ),
    .mcycle_we_o    ( mcycle_we    ),
    .mcycle_wdata_o ( mcycle_wdata )
  );

  hart_cycle_counter cycle_counter_i (
    .clk_i      ( clk_i        ),
    .rst_i      ( rst_i        ),
    .ctrl_fsm_i ( ctrl_fsm     ),
    .we_i       ( mcycle_we    ),
    .wdata_i    ( mcycle_wdata ),
    .count_o    ( mcycle       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////////////////////

  hart_controller_fsm controller_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .irq_ctrl_i     ( irq_ctrl       ),
    .ctrl_fsm_o     ( ctrl_fsm       )
  );

  // Status outputs straight from the controller struct
  assign irq_ack_o    = ctrl_fsm.irq_take;
  assign irq_id_o     = ctrl_fsm.irq_id;
  assign core_sleep_o = ctrl_fsm.sleeping;
  assign active_o     = ctrl_fsm.active;

endmodule

//--- src/hart_controller_fsm.sv
`timescale 1ns/1ps

module hart_controller_fsm (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // Core control
  input  logic                       fetch_enable_i,
  input  logic                       wfi_i,

  // From interrupt controller
  input  hart_ctrl_pkg::irq_ctrl_t   irq_ctrl_i,

  output hart_ctrl_pkg::ctrl_fsm_t   ctrl_fsm_o
);

  hart_ctrl_pkg::ctrl_state_e state_q;
  hart_ctrl_pkg::ctrl_state_e state_d;
  logic                       take_d;
  logic                       irq_take_q;
  hart_ctrl_pkg::irq_id_t     irq_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    take_d  = 1'b0;
    case (state_q)
      hart_ctrl_pkg::RESET: begin
        state_d = hart_ctrl_pkg::BOOT_WAIT;
      end
      hart_ctrl_pkg::BOOT_WAIT: begin
        if (fetch_enable_i) begin
          state_d = hart_ctrl_pkg::ACTIVE;
        end
      end
      hart_ctrl_pkg::ACTIVE: begin
        // Pending interrupt beats wfi in the same cycle
        if (irq_ctrl_i.req) begin
          take_d = 1'b1;
        end else if (wfi_i) begin
          state_d = hart_ctrl_pkg::SLEEP;
        end
      end
      hart_ctrl_pkg::SLEEP: begin
        // Any enabled pending line wakes, MIE or not
        if (irq_ctrl_i.wakeup) begin
          state_d = hart_ctrl_pkg::ACTIVE;
        end
      end
      default: begin
        state_d = hart_ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and acknowledge registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= hart_ctrl_pkg::RESET;
      irq_take_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      irq_take_q <= take_d;
    end
  end

  // ID captured together with the take
  always_ff @(posedge clk_i) begin
    if (take_d) begin
      irq_id_q <= irq_ctrl_i.id;
    end
  end

  assign ctrl_fsm_o.irq_take = irq_take_q;
  assign ctrl_fsm_o.irq_id   = irq_id_q;
  assign ctrl_fsm_o.sleeping = (state_q == hart_ctrl_pkg::SLEEP);
  assign ctrl_fsm_o.active   = (state_q == hart_ctrl_pkg::ACTIVE);

  // MIE is already clear in the ack cycle, so no back-to-back take
  a_take_active: assert property (@(posedge clk_i) disable iff (rst_i)
    take_d |-> !irq_take_q);

endmodule

//--- src/hart_cycle_counter.sv
`timescale 1ns/1ps

module hart_cycle_counter (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // Hart state from controller
  input  hart_ctrl_pkg::ctrl_fsm_t   ctrl_fsm_i,

  // Software load through mcycle
  input  logic                       we_i,
  input  hart_csr_pkg::csr_data_t    wdata_i,

  output hart_csr_pkg::csr_data_t    count_o
);

  hart_csr_pkg::csr_data_t count_q;

  // Load wins over the increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (we_i) begin
      count_q <= wdata_i;
    end else if (ctrl_fsm_i.active) begin
      // Wraps silently at 2^32
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // Sleep freezes the count unless software loads it
  a_hold_in_sleep: assert property (@(posedge clk_i) disable iff (rst_i)
    (ctrl_fsm_i.sleeping && !we_i) |=> (count_q == $past(count_q)));

endmodule

//--- src/hart_cs_registers.sv
`timescale 1ns/1ps

module hart_cs_registers (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // Software CSR port
  input  logic                       csr_we_i,
  input  hart_csr_pkg::csr_addr_t    csr_addr_i,
  input  hart_csr_pkg::csr_data_t    csr_wdata_i,
  output hart_csr_pkg::csr_data_t    csr_rdata_o,

  // Retired mret
  input  logic                       mret_i,

  // From controller FSM
  input  hart_ctrl_pkg::ctrl_fsm_t   ctrl_fsm_i,

  // Read-only sources
  input  hart_csr_pkg::csr_data_t    mip_i,
  input  hart_csr_pkg::csr_data_t    mcycle_i,

  // To interrupt controller
  output hart_csr_pkg::csr_data_t    mie_o,
  output logic                       mstatus_mie_o,

  // To cycle counter
  output logic                       mcycle_we_o,
  output hart_csr_pkg::csr_data_t    mcycle_wdata_o
);

  logic                    mstatus_mie_q;
  logic                    mstatus_mpie_q;
  logic                    mstatus_mie;
  logic                    mstatus_mpie;
  hart_csr_pkg::csr_data_t mie_q;
  logic                    wr_mstatus;
  logic                    wr_mie;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  assign wr_mstatus  = csr_we_i && (csr_addr_i == hart_csr_pkg::CSR_MSTATUS);
  assign wr_mie      = csr_we_i && (csr_addr_i == hart_csr_pkg::CSR_MIE);
  assign mcycle_we_o = csr_we_i && (csr_addr_i == hart_csr_pkg::CSR_MCYCLE);

  assign mcycle_wdata_o = csr_wdata_i;

  // In the ack cycle the hart already sees the trap view of mstatus
  // MIE reads clear and MPIE holds the old MIE
  assign mstatus_mie  = ctrl_fsm_i.irq_take ? 1'b0 : mstatus_mie_q;
  assign mstatus_mpie = ctrl_fsm_i.irq_take ? mstatus_mie_q : mstatus_mpie_q;

  ////////////////////////////////////////////////////////////////////////////
  // mstatus and mie
  ////////////////////////////////////////////////////////////////////////////

  // Take beats mret, mret beats a software write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (ctrl_fsm_i.irq_take) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (wr_mstatus) begin
      // Only MIE and MPIE are writable
      mstatus_mie_q  <= csr_wdata_i[hart_csr_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[hart_csr_pkg::MSTATUS_MPIE_BIT];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q <= '0;
    end else if (wr_mie) begin
      mie_q <= csr_wdata_i & hart_csr_pkg::IRQ_MASK;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      hart_csr_pkg::CSR_MSTATUS: begin
        csr_rdata_o[hart_csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
        csr_rdata_o[hart_csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
      end
      hart_csr_pkg::CSR_MIE:    csr_rdata_o = mie_q;
      hart_csr_pkg::CSR_MIP:    csr_rdata_o = mip_i;
      hart_csr_pkg::CSR_MCYCLE: csr_rdata_o = mcycle_i;
      // Unknown addresses read zero
      default:                  csr_rdata_o = '0;
    endcase
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie;

  // No unimplemented enable bit may ever be set
  a_mie_masked: assert property (@(posedge clk_i) disable iff (rst_i)
    (mie_q & ~hart_csr_pkg::IRQ_MASK) == '0);

endmodule

//--- src/hart_int_controller.sv
`timescale 1ns/1ps

module hart_int_controller (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // Raw interrupt levels
  input  logic [31:0]                irq_i,

  // From CSRs
  input  hart_csr_pkg::csr_data_t    mie_i,
  input  logic                       mstatus_mie_i,

  // Back to CSRs for mip reads
  output hart_csr_pkg::csr_data_t    mip_o,

  // To controller FSM
  output hart_ctrl_pkg::irq_ctrl_t   irq_ctrl_o
);

  hart_csr_pkg::csr_data_t mip_q;
  hart_csr_pkg::csr_data_t pending;
  hart_ctrl_pkg::irq_id_t  irq_id;
  logic                    wakeup;

  // Sample lines once per cycle, unimplemented bits dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & hart_csr_pkg::IRQ_MASK;
    end
  end

  assign pending = mip_q & mie_i;
  assign wakeup  = |pending;

  // Lowest priority first, later hits override
  always_comb begin
    irq_id = '0;
    if (pending[hart_csr_pkg::IRQ_TIMER_BIT]) begin
      irq_id = hart_ctrl_pkg::irq_id_t'(hart_csr_pkg::IRQ_TIMER_BIT);
    end
    if (pending[hart_csr_pkg::IRQ_SOFT_BIT]) begin
      irq_id = hart_ctrl_pkg::irq_id_t'(hart_csr_pkg::IRQ_SOFT_BIT);
    end
    if (pending[hart_csr_pkg::IRQ_EXT_BIT]) begin
      irq_id = hart_ctrl_pkg::irq_id_t'(hart_csr_pkg::IRQ_EXT_BIT);
    end
    // Fast lines on top, 31 highest
    for (int i = hart_csr_pkg::IRQ_FAST_LO; i <= hart_csr_pkg::IRQ_FAST_HI; i++) begin
      if (pending[i]) begin
        irq_id = hart_ctrl_pkg::irq_id_t'(i);
      end
    end
  end

  assign mip_o             = mip_q;
  assign irq_ctrl_o.wakeup = wakeup;
  // Wakeup ignores MIE, the request does not
  assign irq_ctrl_o.req    = wakeup & mstatus_mie_i;
  assign irq_ctrl_o.id     = irq_id;

  // Chosen ID must name a pending and enabled line
  a_id_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ctrl_o.req |-> pending[irq_ctrl_o.id]);

endmodule

//--- src/hart_ctrl_pkg.sv
package hart_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt identification
  ////////////////////////////////////////////////////////////////////////////

  // 32 interrupt lines need a 5 bit number
  localparam int IRQ_ID_W = 5;

  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  ////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RESET,
    BOOT_WAIT,
    ACTIVE,
    SLEEP
  } ctrl_state_e;

  // Interrupt controller to FSM
  typedef struct packed {
    logic    req;
    irq_id_t id;
    logic    wakeup;
  } irq_ctrl_t;

  // FSM to CSRs, counter and top outputs
  typedef struct packed {
    logic    irq_take;
    irq_id_t irq_id;
    logic    sleeping;
    logic    active;
  } ctrl_fsm_t;

endpackage

//--- src/hart_csr_pkg.sv
package hart_csr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // CSR widths and types
  ////////////////////////////////////////////////////////////////////////////

  localparam int CSR_ADDR_W = 12;
  localparam int CSR_DATA_W = 32;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Machine-mode CSR map
  ////////////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MIP     = 12'h344;
  localparam csr_addr_t CSR_MCYCLE  = 12'hB00;

  // mstatus fields kept by this hart
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // Interrupt bit positions shared by mie and mip
  localparam int IRQ_SOFT_BIT  = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;

  // Fast interrupt range, highest number wins
  localparam int IRQ_FAST_LO = 16;
  localparam int IRQ_FAST_HI = 31;

  // Software, timer, external and all sixteen fast lines
  localparam csr_data_t IRQ_MASK = 32'hFFFF_0888;

endpackage
